// File: Makefile
# Verilator build and run for the cluster data-memory testbench

VERILATOR ?= verilator
TOP       ?= tb_cluster_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+include
verilog/mem_pkg.sv
verilog/map_pkg.sv
verilog/dmem_if.sv
verilog/dmem_router.sv
verilog/tcm_ram.sv
verilog/mtimer.sv
verilog/cluster_top.sv
verif/tb_cluster_top.sv

// File: include/cluster_macros.svh
// Widths, address map and TCM depth for the cluster, included by every RTL file that needs them
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define CL_AWIDTH       32
`define CL_DWIDTH       32

// --------------------------------------------------
// Address map
// --------------------------------------------------
// TCM occupies 4 KiB at the bottom of the map
`define CL_TCM_BASE     32'h0000_0000
`define CL_TCM_MASK     32'hFFFF_F000

// Machine timer register block, 32 bytes
`define CL_TIMER_BASE   32'h0049_0000
`define CL_TIMER_MASK   32'hFFFF_FFE0

// TCM depth in 32-bit words
`define CL_TCM_WORDS    1024

`endif

// File: verif/tb_cluster_top.sv
// Self-checking testbench that drives the cluster core port and checks responses against a reference model
`timescale 1ns/100ps

`include "cluster_macros.svh"

module tb_cluster_top;
    import mem_pkg::*;
    import map_pkg::*;

    localparam int TCM_IW     = $clog2(`CL_TCM_WORDS);
    localparam int WAIT_LIMIT = 20;
    localparam int IRQ_LIMIT  = 1000;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   req_i;
    mem_cmd_e               cmd_i;
    mem_width_e             width_i;
    logic [`CL_AWIDTH-1:0]  addr_i;
    logic [`CL_DWIDTH-1:0]  wdata_i;
    logic                   req_ack_o;
    logic [`CL_DWIDTH-1:0]  rdata_o;
    mem_resp_e              resp_o;
    logic                   timer_irq_o;

    // Reference state
    logic [31:0]    shadow [0:`CL_TCM_WORDS-1];
    logic           tmr_en  = 1'b0;
    logic [63:0]    tmr_cmp = '1;
    logic [31:0]    lfsr_state = 32'h4955_39e7;

    // One expectation per accepted request
    mem_resp_e      exp_resp_q [$];
    logic [31:0]    exp_data_q [$];
    logic           exp_chk_q  [$];

    int             errors = 0;
    int             n_resp = 0;
    logic           rsp_cycle;
    mem_resp_e      cmp_resp;
    logic [31:0]    cmp_data;
    logic           cmp_chk;

    cluster_top u_cluster_top (
        .clk_i       (clk_i      ),
        .rst_n_i     (rst_n_i    ),
        .req_i       (req_i      ),
        .cmd_i       (cmd_i      ),
        .width_i     (width_i    ),
        .addr_i      (addr_i     ),
        .wdata_i     (wdata_i    ),
        .req_ack_o   (req_ack_o  ),
        .rdata_o     (rdata_o    ),
        .resp_o      (resp_o     ),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;   // Taps 32,22,2,1
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] tmr_addr(input tmr_reg_e r);
        return `CL_TIMER_BASE + {27'd0, r, 2'b00};
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic void ref_access(input mem_cmd_e cmd, input mem_width_e width,
                                       input logic [31:0] addr, input logic [31:0] wdata,
                                       output mem_resp_e resp, output logic [31:0] rdata,
                                       output logic chk);
        logic [TCM_IW-1:0]  idx;
        tmr_reg_e           off;
        resp  = MEM_RESP_RDY_ER;   // Unmapped unless a region claims it
        rdata = '0;
        chk   = 1'b0;
        if ((addr - `CL_TCM_BASE) < 4 * `CL_TCM_WORDS) begin
            idx  = addr[TCM_IW+1:2];
            resp = MEM_RESP_RDY_OK;
            if (cmd == MEM_CMD_WR) begin
                case (width)
                    MEM_WIDTH_BYTE:  shadow[idx][{addr[1:0], 3'b000} +: 8] = wdata[7:0];
                    MEM_WIDTH_HWORD: shadow[idx][{addr[1], 4'b0000} +: 16] = wdata[15:0];
                    default:         shadow[idx] = wdata;
                endcase
            end else begin
                rdata = shadow[idx];
                chk   = 1'b1;
            end
        end else if ((addr - `CL_TIMER_BASE) < 32'd32) begin
            off = tmr_reg_e'(addr[4:2]);
            if (width == MEM_WIDTH_WORD && off <= TMR_MTIMECMP_HI) begin
                resp = MEM_RESP_RDY_OK;
                if (cmd == MEM_CMD_WR) begin
                    case (off)
                        TMR_CONTROL:     tmr_en = wdata[0];
                        TMR_MTIMECMP_LO: tmr_cmp[31:0] = wdata;
                        TMR_MTIMECMP_HI: tmr_cmp[63:32] = wdata;
                        default:         tmr_en = tmr_en;
                    endcase
                end else begin
                    chk = 1'b1;
                    case (off)
                        TMR_CONTROL:     rdata = {31'd0, tmr_en};
                        TMR_MTIMECMP_LO: rdata = tmr_cmp[31:0];
                        TMR_MTIMECMP_HI: rdata = tmr_cmp[63:32];
                        default:         chk = 1'b0;    // mtime moves every cycle
                    endcase
                end
            end
        end
    endfunction

    // Drives one core request and queues its expected response
    task automatic bus_access(input mem_cmd_e cmd, input mem_width_e width,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        mem_resp_e      e_resp;
        logic [31:0]    e_data;
        logic           e_chk;
        int             waited;
        @(posedge clk_i);
        #1;
        req_i   = 1'b1;
        cmd_i   = cmd;
        width_i = width;
        addr_i  = addr;
        wdata_i = wdata;
        waited  = 0;
        @(negedge clk_i);
        while (!req_ack_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (req_ack_o === 1'b1) else begin
            errors++;
            $display("Request to address %h was never acknowledged", addr);
        end
        if (req_ack_o === 1'b1) begin
            ref_access(cmd, width, addr, wdata, e_resp, e_data, e_chk);
            exp_resp_q.push_back(e_resp);
            exp_data_q.push_back(e_data);
            exp_chk_q.push_back(e_chk);
        end
        @(posedge clk_i);
        #1;
        req_i  = 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (resp_o == MEM_RESP_NOTRDY && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (resp_o !== MEM_RESP_NOTRDY) else begin
            errors++;
            $display("No response for the request to address %h", addr);
        end
        rdata = rdata_o;
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (timer_irq_o !== level && waited < IRQ_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (timer_irq_o === level) else begin
            errors++;
            $display("timer_irq_o did not go to %0b within %0d cycles", level, IRQ_LIMIT);
        end
    endtask

    // --------------------------------------------------
    // Compare process sampling at the falling edge
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            rsp_cycle = 1'b0;
        end else begin
            if (rsp_cycle) begin
                n_resp++;
                assert (req_ack_o === 1'b0) else begin
                    errors++;
                    $display("error at %0t: req_ack_o = %b, expected 0", $time, req_ack_o);
                end
                assert (exp_resp_q.size() > 0) else begin
                    errors++;
                    $display("Response at %0t without a queued expectation", $time);
                end
                if (exp_resp_q.size() > 0) begin
                    cmp_resp = exp_resp_q.pop_front();
                    cmp_data = exp_data_q.pop_front();
                    cmp_chk  = exp_chk_q.pop_front();
                    assert (resp_o === cmp_resp) else begin
                        errors++;
                        $display("error at %0t: resp_o = %s, expected %s",
                                 $time, resp_o.name(), cmp_resp.name());
                    end
                    if (cmp_chk) begin
                        assert (rdata_o === cmp_data) else begin
                            errors++;
                            $display("error at %0t: rdata_o = %h, expected %h",
                                     $time, rdata_o, cmp_data);
                        end
                    end
                end
            end else begin
                assert (resp_o === MEM_RESP_NOTRDY) else begin
                    errors++;
                    $display("error at %0t: resp_o = %s, expected MEM_RESP_NOTRDY",
                             $time, resp_o.name());
                end
                assert (req_ack_o === 1'b1) else begin
                    errors++;
                    $display("error at %0t: req_ack_o = %b, expected 1", $time, req_ack_o);
                end
            end
            rsp_cycle = req_i & req_ack_o;      // Response due next cycle
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0]    addr;
        logic [31:0]    rd;
        logic [31:0]    tcm_addrs [$];
        mem_width_e     width;
        req_i   = 1'b0;
        cmd_i   = MEM_CMD_RD;
        width_i = MEM_WIDTH_WORD;
        addr_i  = '0;
        wdata_i = '0;
        rst_n_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        assert (timer_irq_o === 1'b0) else begin
            errors++;
            $display("error at %0t: timer_irq_o = %b, expected 0", $time, timer_irq_o);
        end

        // Timer comes out of reset disabled with mtime at zero and mtimecmp at all ones
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_CONTROL), '0, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_LO), '0, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI), '0, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIME_LO), '0, rd);
        assert (rd === 32'd0) else begin
            errors++;
            $display("error at %0t: rdata_o = %h, expected %h", $time, rd, 32'd0);
        end

        // Random word traffic across the TCM
        for (int i = 0; i < 48; i++) begin
            addr = `CL_TCM_BASE | (random_bits(TCM_IW) << 2);
            tcm_addrs.push_back(addr);
            bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, addr, random_bits(32), rd);
        end
        foreach (tcm_addrs[i]) bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tcm_addrs[i], '0, rd);

        // Byte and half merges into known words
        for (int i = 0; i < 32; i++) begin
            addr = tcm_addrs[random_bits(5)];
            if (random_bits(1) != 0) begin
                width = MEM_WIDTH_HWORD;
                addr  = addr | (random_bits(1) << 1);
            end else begin
                width = MEM_WIDTH_BYTE;
                addr  = addr | random_bits(2);
            end
            bus_access(MEM_CMD_WR, width, addr, random_bits(32), rd);
            bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, addr & ~32'h3, '0, rd);
        end

        // Unmapped addresses that alias TCM words must leave them unchanged
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_CONTROL) + 32'h20, '1, rd);
        for (int i = 0; i < 8; i++) begin
            addr = 32'h0100_0000 | tcm_addrs[i];
            bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, addr, random_bits(32), rd);
            bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, addr, '0, rd);
            bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tcm_addrs[i], '0, rd);
        end

        // Compare register and non-word timer accesses
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_LO), random_bits(32), rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI), random_bits(32), rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_LO), '0, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI), '0, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_BYTE, tmr_addr(TMR_MTIMECMP_LO), '1, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_HWORD, tmr_addr(TMR_MTIMECMP_HI), '1, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_BYTE, tmr_addr(TMR_CONTROL), 32'd1, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_HWORD, tmr_addr(TMR_CONTROL), '0, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI) + 32'h4, '1, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_LO), '0, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI), '0, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_CONTROL), '0, rd);

        // Interrupt rise and fall
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI), 32'd0, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_LO), 32'd300, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIME_HI), 32'd0, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIME_LO), 32'd100, rd);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_CONTROL), 32'd1, rd);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_MTIME_LO), '0, rd);
        assert (rd >= 32'd100) else begin
            errors++;
            $display("error at %0t: rdata_o = %0d, expected at least 100", $time, rd);
        end
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, tmr_addr(TMR_CONTROL), '0, rd);
        wait_irq(1'b1);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, tmr_addr(TMR_MTIMECMP_HI), 32'h0000_1000, rd);
        wait_irq(1'b0);

        repeat (3) @(posedge clk_i);
        $display("Run complete: %0d errors over %0d responses", errors, n_resp);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_cluster_top

// File: verilog/cluster_top.sv
// Cluster data-memory top level: one core port routed to the TCM and the machine timer
`timescale 1ns/100ps

`include "cluster_macros.svh"

module cluster_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Core data-memory port
    input  logic                    req_i,
    input  mem_pkg::mem_cmd_e       cmd_i,
    input  mem_pkg::mem_width_e     width_i,
    input  logic [`CL_AWIDTH-1:0]   addr_i,
    input  logic [`CL_DWIDTH-1:0]   wdata_i,
    output logic                    req_ack_o,
    output logic [`CL_DWIDTH-1:0]   rdata_o,
    output mem_pkg::mem_resp_e      resp_o,
    // Timer interrupt
    output logic                    timer_irq_o
);

    dmem_if tcm_bus ();
    dmem_if tmr_bus ();

    // --------------------------------------------------
    // Router, the only master on both target buses
    // --------------------------------------------------
    dmem_router u_router (
        .clk_i      (clk_i      ),
        .rst_n_i    (rst_n_i    ),
        .req_i      (req_i      ),
        .cmd_i      (cmd_i      ),
        .width_i    (width_i    ),
        .addr_i     (addr_i     ),
        .wdata_i    (wdata_i    ),
        .req_ack_o  (req_ack_o  ),
        .rdata_o    (rdata_o    ),
        .resp_o     (resp_o     ),
        .tcm_m      (tcm_bus    ),
        .tmr_m      (tmr_bus    )
    );

    tcm_ram u_tcm (
        .clk_i      (clk_i      ),
        .rst_n_i    (rst_n_i    ),
        .bus_s      (tcm_bus    )
    );

    mtimer u_timer (
        .clk_i       (clk_i      ),
        .rst_n_i     (rst_n_i    ),
        .bus_s       (tmr_bus    ),
        .timer_irq_o (timer_irq_o)
    );

endmodule : cluster_top

// File: verilog/dmem_if.sv
// Data-memory request/response bundle between the router and each target
`timescale 1ns/100ps

`include "cluster_macros.svh"

interface dmem_if;
    import mem_pkg::*;

    // Request side, driven by the router
    logic                   req;
    mem_cmd_e               cmd;
    mem_width_e             width;
    logic [`CL_AWIDTH-1:0]  addr;
    logic [`CL_DWIDTH-1:0]  wdata;

    // Response side, driven by the target
    logic                   req_ack;
    logic [`CL_DWIDTH-1:0]  rdata;
    mem_resp_e              resp;

    modport master (
        output req,
        output cmd,
        output width,
        output addr,
        output wdata,
        input  req_ack,
        input  rdata,
        input  resp
    );

    modport slave (
        input  req,
        input  cmd,
        input  width,
        input  addr,
        input  wdata,
        output req_ack,
        output rdata,
        output resp
    );

endinterface : dmem_if

// File: verilog/dmem_router.sv
// Decodes core data-memory requests to the TCM, the timer or an error reply, and returns responses
`timescale 1ns/100ps

`include "cluster_macros.svh"

module dmem_router (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Core side
    input  logic                    req_i,
    input  mem_pkg::mem_cmd_e       cmd_i,
    input  mem_pkg::mem_width_e     width_i,
    input  logic [`CL_AWIDTH-1:0]   addr_i,
    input  logic [`CL_DWIDTH-1:0]   wdata_i,
    output logic                    req_ack_o,
    output logic [`CL_DWIDTH-1:0]   rdata_o,
    output mem_pkg::mem_resp_e      resp_o,
    // Targets
    dmem_if.master                  tcm_m,
    dmem_if.master                  tmr_m
);
    import mem_pkg::*;
    import map_pkg::*;

    tgt_sel_e   sel;
    tgt_sel_e   sel_q;          // Target of the request in flight
    logic       rsp_due_q;
    logic       tgt_ack;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    always_comb begin
        if ((addr_i & `CL_TCM_MASK) == `CL_TCM_BASE) begin
            sel = TGT_TCM;
        end else if ((addr_i & `CL_TIMER_MASK) == `CL_TIMER_BASE) begin
            sel = TGT_TMR;
        end else begin
            sel = TGT_NONE;
        end
    end

    always_comb begin
        case (sel)
            TGT_TCM: tgt_ack = tcm_m.req_ack;
            TGT_TMR: tgt_ack = tmr_m.req_ack;
            default: tgt_ack = 1'b1;    // Unmapped, acked locally
        endcase
    end

    // No new request while a response is due
    assign req_ack_o = ~rsp_due_q & tgt_ack;

    assign tcm_m.req   = req_i & ~rsp_due_q & (sel == TGT_TCM);
    assign tcm_m.cmd   = cmd_i;
    assign tcm_m.width = width_i;
    assign tcm_m.addr  = addr_i;
    assign tcm_m.wdata = wdata_i;

    assign tmr_m.req   = req_i & ~rsp_due_q & (sel == TGT_TMR);
    assign tmr_m.cmd   = cmd_i;
    assign tmr_m.width = width_i;
    assign tmr_m.addr  = addr_i;
    assign tmr_m.wdata = wdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_due_q <= 1'b0;
            sel_q     <= TGT_NONE;
        end else begin
            rsp_due_q <= req_i & req_ack_o;
            if (req_i && req_ack_o) begin
                sel_q <= sel;
            end
        end
    end

    // --------------------------------------------------
    // Response steering
    // --------------------------------------------------
    always_comb begin
        resp_o  = MEM_RESP_NOTRDY;
        rdata_o = '0;
        if (rsp_due_q) begin
            case (sel_q)
                TGT_TCM: begin
                    resp_o  = tcm_m.resp;
                    rdata_o = tcm_m.rdata;
                end
                TGT_TMR: begin
                    resp_o  = tmr_m.resp;
                    rdata_o = tmr_m.rdata;
                end
                default: resp_o = MEM_RESP_RDY_ER;
            endcase
        end
    end

    // Targets only answer the request the router sent them
    a_tcm_resp_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tcm_m.resp != MEM_RESP_NOTRDY) |-> (rsp_due_q && sel_q == TGT_TCM))
        else $error("TCM response without a routed request");

    a_tmr_resp_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tmr_m.resp != MEM_RESP_NOTRDY) |-> (rsp_due_q && sel_q == TGT_TMR))
        else $error("Timer response without a routed request");

endmodule : dmem_router

// File: verilog/map_pkg.sv
// Address-map types for the router target select and the timer register offsets
package map_pkg;

    // Router target select
    typedef enum logic [1:0] {
        TGT_TCM  = 2'd0,
        TGT_TMR  = 2'd1,
        TGT_NONE = 2'd2     // Unmapped, router answers with error
    } tgt_sel_e;

    // --------------------------------------------------
    // Timer registers by word offset
    // --------------------------------------------------
    typedef enum logic [2:0] {
        TMR_CONTROL     = 3'd0,     // Bit 0 is enable
        TMR_MTIME_LO    = 3'd1,
        TMR_MTIME_HI    = 3'd2,
        TMR_MTIMECMP_LO = 3'd3,
        TMR_MTIMECMP_HI = 3'd4
    } tmr_reg_e;

endpackage : map_pkg

// File: verilog/mem_pkg.sv
// Data-memory protocol types shared by the core port, the router and the targets
package mem_pkg;

    // --------------------------------------------------
    // Request command
    // --------------------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // --------------------------------------------------
    // Access size
    // --------------------------------------------------
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // --------------------------------------------------
    // Response code, valid one cycle after acceptance
    // --------------------------------------------------
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,    // No response this cycle
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10     // Decode or access error
    } mem_resp_e;

endpackage : mem_pkg

// File: verilog/mtimer.sv
// Memory-mapped 64-bit machine timer with compare register and interrupt, a slave of the router
`timescale 1ns/100ps

`include "cluster_macros.svh"

module mtimer (
    input  logic    clk_i,
    input  logic    rst_n_i,
    dmem_if.slave   bus_s,
    output logic    timer_irq_o
);
    import mem_pkg::*;
    import map_pkg::*;

    tmr_reg_e               reg_sel;
    logic                   accept;
    logic                   acc_ok;         // Word access to a mapped register
    logic                   wr_ok;
    logic                   enable_q;
    logic                   enable_nxt;
    logic [63:0]            mtime_q;
    logic [63:0]            mtime_nxt;
    logic [63:0]            mtimecmp_q;
    logic [63:0]            mtimecmp_nxt;
    logic                   irq_q;
    logic [`CL_DWIDTH-1:0]  rdata_q;
    mem_resp_e              resp_q;

    assign bus_s.req_ack = 1'b1;
    assign accept  = bus_s.req & bus_s.req_ack;
    assign reg_sel = tmr_reg_e'(bus_s.addr[4:2]);
    assign acc_ok  = (bus_s.width == MEM_WIDTH_WORD) && (reg_sel <= TMR_MTIMECMP_HI);
    assign wr_ok   = accept & acc_ok & (bus_s.cmd == MEM_CMD_WR);

    // --------------------------------------------------
    // Next-state for counter, compare and control
    // --------------------------------------------------
    always_comb begin
        enable_nxt   = enable_q;
        mtime_nxt    = enable_q ? mtime_q + 64'd1 : mtime_q;
        mtimecmp_nxt = mtimecmp_q;
        if (wr_ok) begin
            case (reg_sel)
                TMR_CONTROL:     enable_nxt = bus_s.wdata[0];
                TMR_MTIME_LO:    mtime_nxt = {mtime_q[63:32], bus_s.wdata};  // Write wins
                TMR_MTIME_HI:    mtime_nxt = {bus_s.wdata, mtime_q[31:0]};
                TMR_MTIMECMP_LO: mtimecmp_nxt[31:0] = bus_s.wdata;
                TMR_MTIMECMP_HI: mtimecmp_nxt[63:32] = bus_s.wdata;
                default:         enable_nxt = enable_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q   <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
            resp_q     <= MEM_RESP_NOTRDY;
        end else begin
            enable_q   <= enable_nxt;
            mtime_q    <= mtime_nxt;
            mtimecmp_q <= mtimecmp_nxt;
            irq_q      <= enable_nxt & (mtime_nxt >= mtimecmp_nxt);
            if (accept) resp_q <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
            else        resp_q <= MEM_RESP_NOTRDY;
        end
    end

    // Read mux, sampled at acceptance
    always_ff @(posedge clk_i) begin
        if (accept && bus_s.cmd == MEM_CMD_RD) begin
            case (reg_sel)
                TMR_CONTROL:     rdata_q <= {31'd0, enable_q};
                TMR_MTIME_LO:    rdata_q <= mtime_q[31:0];
                TMR_MTIME_HI:    rdata_q <= mtime_q[63:32];
                TMR_MTIMECMP_LO: rdata_q <= mtimecmp_q[31:0];
                TMR_MTIMECMP_HI: rdata_q <= mtimecmp_q[63:32];
                default:         rdata_q <= '0;
            endcase
        end
    end

    assign bus_s.resp  = resp_q;
    assign bus_s.rdata = rdata_q;
    assign timer_irq_o = irq_q;

    a_irq_needs_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        timer_irq_o |-> enable_q)
        else $error("Timer interrupt raised while disabled");

endmodule : mtimer

// File: verilog/tcm_ram.sv
// Single-cycle tightly coupled word memory with byte-lane writes, a slave of the router
`timescale 1ns/100ps

`include "cluster_macros.svh"

module tcm_ram (
    input  logic    clk_i,
    input  logic    rst_n_i,
    dmem_if.slave   bus_s
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`CL_TCM_WORDS);

    logic [`CL_DWIDTH-1:0]  mem [0:`CL_TCM_WORDS-1];
    logic [IDX_W-1:0]       idx;
    logic [3:0]             be;             // Byte lane enables
    logic [`CL_DWIDTH-1:0]  lane_data;
    logic                   accept;
    logic [`CL_DWIDTH-1:0]  rdata_q;
    mem_resp_e              resp_q;

    assign bus_s.req_ack = 1'b1;            // Always ready
    assign accept        = bus_s.req & bus_s.req_ack;
    assign idx           = bus_s.addr[IDX_W+1:2];

    // --------------------------------------------------
    // Lane selection from access width
    // --------------------------------------------------
    always_comb begin
        case (bus_s.width)
            MEM_WIDTH_BYTE: begin
                be        = 4'b0001 << bus_s.addr[1:0];
                lane_data = {4{bus_s.wdata[7:0]}};
            end
            MEM_WIDTH_HWORD: begin
                be        = bus_s.addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{bus_s.wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = bus_s.wdata;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (accept && bus_s.cmd == MEM_CMD_WR) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
        if (accept && bus_s.cmd == MEM_CMD_RD) begin
            rdata_q <= mem[idx];            // Full word, core picks lanes
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) resp_q <= MEM_RESP_NOTRDY;
        else          resp_q <= accept ? MEM_RESP_RDY_OK : MEM_RESP_NOTRDY;
    end

    assign bus_s.resp  = resp_q;
    assign bus_s.rdata = rdata_q;

    a_tcm_in_region: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> ((bus_s.addr & `CL_TCM_MASK) == `CL_TCM_BASE))
        else $error("TCM accepted an address outside its region");

endmodule : tcm_ram
